//--- hdl/memPkg.sv
package memPkg;

    // byte address into the shared RAM
    localparam int addrWidth = 17;

    // client side word and RAM side byte
    localparam int wordWidth = 32;
    localparam int byteWidth = 8;

    localparam int lenWidth = 2;

    // access length of 1, 2 or 4 bytes
    localparam logic [lenWidth-1:0] lenOne  = 2'd0;
    localparam logic [lenWidth-1:0] lenTwo  = 2'd1;
    localparam logic [lenWidth-1:0] lenFour = 2'd2;

    // access direction
    localparam logic kindLoad  = 1'b0;
    localparam logic kindStore = 1'b1;

endpackage

//--- hdl/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          fetchReq,
    input  logic [memPkg::addrWidth-1:0]  fetchAddr,
    input  logic                          dataReq,
    input  logic                          dataKind,
    input  logic [memPkg::lenWidth-1:0]   dataLen,
    input  logic [memPkg::addrWidth-1:0]  dataAddr,
    input  logic [memPkg::wordWidth-1:0]  dataWdata,
    input  logic                          done,
    input  logic [memPkg::wordWidth-1:0]  rdata,
    output logic                          fetchAck,
    output logic [memPkg::wordWidth-1:0]  fetchInst,
    output logic                          dataAck,
    output logic [memPkg::wordWidth-1:0]  dataRdata,
    output logic                          start,
    output logic                          kind,
    output logic [memPkg::lenWidth-1:0]   len,
    output logic [memPkg::addrWidth-1:0]  addr,
    output logic [memPkg::wordWidth-1:0]  wdata
);

    localparam logic [1:0] stateIdle    = 2'd0;
    localparam logic [1:0] stateBusy    = 2'd1;
    localparam logic [1:0] stateAck     = 2'd2;
    localparam logic [1:0] stateRelease = 2'd3;

    logic [1:0] state;
    logic       grantData;
    logic       grantReq;

    // req of whichever client holds the grant
    assign grantReq = grantData ? dataReq : fetchReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stateIdle;
            grantData <= 1'b0;
            start     <= 1'b0;
            fetchAck  <= 1'b0;
            dataAck   <= 1'b0;
        end else if (!stall) begin
            case (state)
                stateIdle: begin
                    // data side wins a tie
                    if (dataReq || fetchReq) begin
                        grantData <= dataReq;
                        start     <= 1'b1;
                        state     <= stateBusy;
                    end
                end
                stateBusy: begin
                    start <= 1'b0;
                    if (done) begin
                        fetchAck <= !grantData;
                        dataAck  <= grantData;
                        state    <= stateAck;
                    end
                end
                stateAck: begin
                    if (!grantReq) begin
                        fetchAck <= 1'b0;
                        dataAck  <= 1'b0;
                        state    <= stateRelease;
                    end
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == stateIdle && dataReq) begin
                kind  <= dataKind;
                len   <= dataLen;
                addr  <= dataAddr;
                wdata <= dataWdata;
            end else if (state == stateIdle && fetchReq) begin
                // instruction fetch is a plain word load
                kind  <= memPkg::kindLoad;
                len   <= memPkg::lenFour;
                addr  <= fetchAddr;
                wdata <= '0;
            end
            if (state == stateBusy && done) begin
                if (grantData) begin
                    dataRdata <= rdata;
                end else begin
                    fetchInst <= rdata;
                end
            end
        end
    end

endmodule

//--- hdl/byteSequencer.sv
`timescale 1ns/1ps

module byteSequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          start,
    input  logic                          kind,
    input  logic [memPkg::lenWidth-1:0]   len,
    input  logic [memPkg::addrWidth-1:0]  addr,
    input  logic [memPkg::wordWidth-1:0]  wdata,
    input  logic [memPkg::byteWidth-1:0]  ramRdata,
    output logic                          done,
    output logic [memPkg::wordWidth-1:0]  rdata,
    output logic [memPkg::addrWidth-1:0]  ramAddr,
    output logic                          ramWe,
    output logic [memPkg::byteWidth-1:0]  ramWdata
);

    // control state
    logic                          busy;
    logic [2:0]                    idx;

    // access held for the length of the transfer
    logic                          kindReg;
    logic [2:0]                    countReg;
    logic [memPkg::addrWidth-1:0]  baseAddr;
    logic [memPkg::wordWidth-1:0]  wdataReg;
    logic [memPkg::wordWidth-1:0]  assembly;

    logic [2:0]                    startCount;
    logic [2:0]                    offset;
    logic [1:0]                    capLane;
    logic [memPkg::addrWidth-1:0]  curBase;
    logic [memPkg::wordWidth-1:0]  curWord;
    logic                          issueWrite;
    logic                          lastByte;

    function automatic logic [2:0] byteCount(input logic [memPkg::lenWidth-1:0] code);
        case (code)
            memPkg::lenOne:  return 3'd1;
            memPkg::lenTwo:  return 3'd2;
            memPkg::lenFour: return 3'd4;
            default:         return 3'd4;
        endcase
    endfunction

    assign startCount = byteCount(len);

    // first byte goes out in the start cycle, straight from the request fields
    assign curBase = busy ? baseAddr : addr;
    assign curWord = busy ? wdataReg : wdata;

    // while stalled, re-read the byte still waiting for capture
    assign offset = busy ? (stall ? idx - 3'd1 : idx) : 3'd0;

    // returned byte belongs to the address issued one cycle earlier
    assign capLane = idx[1:0] - 2'd1;

    assign ramAddr  = curBase + {{(memPkg::addrWidth - 3){1'b0}}, offset};
    assign ramWdata = curWord[offset[1:0] * memPkg::byteWidth +: memPkg::byteWidth];

    assign issueWrite = busy ? (kindReg == memPkg::kindStore)
                             : (start && kind == memPkg::kindStore);
    assign ramWe = issueWrite && !stall;

    // stores end on their last write, loads one cycle later on the last capture
    always_comb begin
        if (!busy) begin
            lastByte = (kind == memPkg::kindStore) && (startCount == 3'd1);
        end else if (kindReg == memPkg::kindStore) begin
            lastByte = (idx == countReg - 3'd1);
        end else begin
            lastByte = (idx == countReg);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= 3'd0;
            done <= 1'b0;
        end else if (!stall) begin
            busy <= (busy || start) && !lastByte;
            done <= (busy || start) && lastByte;
            idx  <= busy ? idx + 3'd1 : 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (!busy && start) begin
                kindReg  <= kind;
                countReg <= startCount;
                baseAddr <= addr;
                wdataReg <= wdata;
                // lanes above the length stay zero
                assembly <= '0;
            end else if (busy && kindReg == memPkg::kindLoad) begin
                assembly[capLane * memPkg::byteWidth +: memPkg::byteWidth] <= ramRdata;
            end
        end
    end

    assign rdata = assembly;

endmodule

//--- hdl/byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int ramDepth = 131072
) (
    input  logic                          clk,
    input  logic [memPkg::addrWidth-1:0]  ramAddr,
    input  logic                          ramWe,
    input  logic [memPkg::byteWidth-1:0]  ramWdata,
    output logic [memPkg::byteWidth-1:0]  ramRdata
);

    // low address bits select the byte
    localparam int indexWidth = (ramDepth > 1) ? $clog2(ramDepth) : 1;

    logic [memPkg::byteWidth-1:0] mem [ramDepth];
    logic [indexWidth-1:0]        index;

    assign index = ramAddr[indexWidth-1:0];

    // read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[index] <= ramWdata;
        end
        ramRdata <= mem[index];
    end

endmodule

//--- hdl/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem #(
    parameter int ramDepth = 131072
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          fetchReq,
    input  logic [memPkg::addrWidth-1:0]  fetchAddr,
    output logic                          fetchAck,
    output logic [memPkg::wordWidth-1:0]  fetchInst,
    input  logic                          dataReq,
    input  logic                          dataKind,
    input  logic [memPkg::lenWidth-1:0]   dataLen,
    input  logic [memPkg::addrWidth-1:0]  dataAddr,
    input  logic [memPkg::wordWidth-1:0]  dataWdata,
    output logic                          dataAck,
    output logic [memPkg::wordWidth-1:0]  dataRdata
);

    // arbiter to sequencer
    logic                          seqStart;
    logic                          seqKind;
    logic [memPkg::lenWidth-1:0]   seqLen;
    logic [memPkg::addrWidth-1:0]  seqAddr;
    logic [memPkg::wordWidth-1:0]  seqWdata;
    logic                          seqDone;
    logic [memPkg::wordWidth-1:0]  seqRdata;

    // sequencer to RAM
    logic [memPkg::addrWidth-1:0]  ramAddr;
    logic                          ramWe;
    logic [memPkg::byteWidth-1:0]  ramWdata;
    logic [memPkg::byteWidth-1:0]  ramRdata;

    memArbiter memArbiter_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .dataReq   (dataReq),
        .dataKind  (dataKind),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .done      (seqDone),
        .rdata     (seqRdata),
        .fetchAck  (fetchAck),
        .fetchInst (fetchInst),
        .dataAck   (dataAck),
        .dataRdata (dataRdata),
        .start     (seqStart),
        .kind      (seqKind),
        .len       (seqLen),
        .addr      (seqAddr),
        .wdata     (seqWdata)
    );

    byteSequencer byteSequencer_i (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .start    (seqStart),
        .kind     (seqKind),
        .len      (seqLen),
        .addr     (seqAddr),
        .wdata    (seqWdata),
        .ramRdata (ramRdata),
        .done     (seqDone),
        .rdata    (seqRdata),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata)
    );

    byteRam #(
        .ramDepth (ramDepth)
    ) byteRam_i (
        .clk      (clk),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

//--- verif/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 50,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        // release on a falling edge like every other input
        @(negedge clk);
        rst = 1'b0;
    end

    always #halfPeriod clk = !clk;

endmodule

//--- verif/memSubsystem_props.sv
`timescale 1ns/1ps

module memSubsystemProps (
    input logic                          clk,
    input logic                          rst,
    input logic                          stall,
    input logic                          fetchReq,
    input logic                          fetchAck,
    input logic [memPkg::wordWidth-1:0]  fetchInst,
    input logic                          dataReq,
    input logic                          dataAck,
    input logic [memPkg::wordWidth-1:0]  dataRdata
);

    // ack may outlive req by the release cycle, or longer while stalled
    fetchAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        fetchAck |-> fetchReq || $past(fetchReq) || $past(stall))
        else $error("fetchAck is high without a fetch request");

    dataAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        dataAck |-> dataReq || $past(dataReq) || $past(stall))
        else $error("dataAck is high without a data request");

    oneAckAtATime: assert property (@(posedge clk) disable iff (rst)
        !(fetchAck && dataAck))
        else $error("fetchAck and dataAck are high together");

    fetchResultStable: assert property (@(posedge clk) disable iff (rst)
        fetchAck && $past(fetchAck) |-> $stable(fetchInst))
        else $error("fetchInst changed while fetchAck was high");

    dataResultStable: assert property (@(posedge clk) disable iff (rst)
        dataAck && $past(dataAck) |-> $stable(dataRdata))
        else $error("dataRdata changed while dataAck was high");

endmodule

bind memSubsystem memSubsystemProps memSubsystemProps_i (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .fetchReq  (fetchReq),
    .fetchAck  (fetchAck),
    .fetchInst (fetchInst),
    .dataReq   (dataReq),
    .dataAck   (dataAck),
    .dataRdata (dataRdata)
);

//--- verif/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;

    typedef logic [memPkg::addrWidth-1:0] addrType;
    typedef logic [memPkg::wordWidth-1:0] wordType;

    localparam int      ramDepth    = 131072;
    localparam int      maxStall    = 4;
    localparam int      randomCount = 40;
    localparam addrType windowBase  = 'h05000;

    // fetch and data exchanges issued by the five tests together
    localparam int requestCount = 3 + 9 + 4 + 9 + 8 + randomCount;
    localparam int cycleLimit   = requestCount * (6 + maxStall) + 200;

    logic                         clk;
    logic                         rst;
    logic                         stall;
    logic                         fetchReq;
    addrType                      fetchAddr;
    logic                         fetchAck;
    wordType                      fetchInst;
    logic                         dataReq;
    logic                         dataKind;
    logic [memPkg::lenWidth-1:0]  dataLen;
    addrType                      dataAddr;
    wordType                      dataWdata;
    logic                         dataAck;
    wordType                      dataRdata;

    // byte image of what the RAM should hold
    logic [7:0]  refMem [ramDepth];
    logic [31:0] lcgState    = 32'h1a30f476;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycleCount  = 0;

    clockGen clockGen_i (
        .clk (clk),
        .rst (rst)
    );

    memSubsystem #(
        .ramDepth (ramDepth)
    ) memSubsystem_i (.*);

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [memPkg::lenWidth-1:0] lenCode(input int nBytes);
        if (nBytes == 1) return memPkg::lenOne;
        if (nBytes == 2) return memPkg::lenTwo;
        return memPkg::lenFour;
    endfunction

    // little-endian with lanes above the length read as zero
    function automatic wordType modelRead(input addrType a, input int nBytes);
        wordType w;
        w = '0;
        for (int k = 0; k < nBytes; k++) begin
            w[k*8 +: 8] = refMem[a + addrType'(k)];
        end
        return w;
    endfunction

    task automatic modelWrite(input addrType a, input int nBytes, input wordType w);
        for (int k = 0; k < nBytes; k++) begin
            refMem[a + addrType'(k)] = w[k*8 +: 8];
        end
    endtask

    task automatic reportMismatch(input string testName, input wordType expected,
                                  input wordType actual);
        valueErrors++;
        $display("[ERROR] %s: expected %08h, actual %08h", testName, expected, actual);
    endtask

    // called and left on a falling edge
    task automatic fetchRead(input addrType a, output wordType inst);
        fetchAddr = a;
        fetchReq = 1'b1;
        while (!fetchAck) @(negedge clk);
        inst = fetchInst;
        fetchReq = 1'b0;
        while (fetchAck) @(negedge clk);
    endtask

    task automatic dataAccess(input logic isStore, input int nBytes, input addrType a,
                              input wordType wd, output wordType rd);
        dataKind = isStore ? memPkg::kindStore : memPkg::kindLoad;
        dataLen = lenCode(nBytes);
        dataAddr = a;
        dataWdata = wd;
        dataReq = 1'b1;
        while (!dataAck) @(negedge clk);
        rd = dataRdata;
        dataReq = 1'b0;
        while (dataAck) @(negedge clk);
        if (isStore) modelWrite(a, nBytes, wd);
    endtask

    task automatic storeData(input addrType a, input int nBytes, input wordType wd);
        wordType ignored;
        dataAccess(1'b1, nBytes, a, wd, ignored);
    endtask

    task automatic checkLoad(input string testName, input addrType a, input int nBytes);
        wordType got;
        wordType expected;
        expected = modelRead(a, nBytes);
        dataAccess(1'b0, nBytes, a, '0, got);
        if (got !== expected) reportMismatch(testName, expected, got);
    endtask

    task automatic checkFetch(input string testName, input addrType a);
        wordType got;
        wordType expected;
        expected = modelRead(a, 4);
        fetchRead(a, got);
        if (got !== expected) reportMismatch(testName, expected, got);
    endtask

    task automatic stallBurst();
        logic [31:0] delay;
        logic [31:0] span;
        delay = lcgNext() % 32'd6;
        span = 32'd1 + lcgNext() % maxStall;
        repeat (delay) @(negedge clk);
        stall = 1'b1;
        repeat (span) @(negedge clk);
        stall = 1'b0;
    endtask

    task automatic wordStoreReadBack();
        logic [31:0] r;
        addrType     a;
        r = lcgNext();
        a = {r[16:2], 2'b00};
        storeData(a, 4, lcgNext());
        checkFetch("wordStoreReadBack", a);
        checkLoad("wordStoreReadBack", a, 4);
    endtask

    task automatic narrowAccess();
        logic [31:0] r;
        addrType     a;
        r = lcgNext();
        a = {r[16:2], 2'b00};
        storeData(a, 4, lcgNext());
        // upper wdata bits are random and must not reach the RAM
        storeData(a + addrType'(1), 1, lcgNext());
        storeData(a + addrType'(2), 2, lcgNext());
        checkLoad("narrowAccess", a, 4);
        checkLoad("narrowAccess", a + addrType'(1), 1);
        checkLoad("narrowAccess", a + addrType'(2), 2);
        checkLoad("narrowAccess", a, 2);
        checkLoad("narrowAccess", a + addrType'(3), 1);
        checkFetch("narrowAccess", a);
    endtask

    task automatic simultaneousRequests();
        logic [31:0] r;
        addrType     a;
        addrType     b;
        wordType     expFetch;
        wordType     expData;
        wordType     gotFetch;
        wordType     gotData;
        logic        dataFirst;
        r = lcgNext();
        a = {r[16:2], 2'b00};
        b = a ^ addrType'('h100);
        storeData(a, 4, lcgNext());
        storeData(b, 4, lcgNext());
        expFetch = modelRead(a, 4);
        expData = modelRead(b, 4);
        fork
            fetchRead(a, gotFetch);
            dataAccess(1'b0, 4, b, '0, gotData);
            begin
                while (!fetchAck && !dataAck) @(negedge clk);
                dataFirst = dataAck;
            end
        join
        if (!dataFirst) begin
            otherErrors++;
            $display("simultaneousRequests: the fetch was answered before the data access");
        end
        if (gotFetch !== expFetch) reportMismatch("simultaneousRequests", expFetch, gotFetch);
        if (gotData !== expData) reportMismatch("simultaneousRequests", expData, gotData);
    endtask

    task automatic stallDuringAccess();
        logic [31:0] r;
        addrType     a;
        wordType     wd;
        for (int i = 0; i < 3; i++) begin
            r = lcgNext();
            a = {r[16:2], 2'b00};
            wd = lcgNext();
            fork
                storeData(a, 4, wd);
                stallBurst();
            join
            fork
                checkLoad("stallDuringAccess", a, 1 << i);
                stallBurst();
            join
            fork
                checkFetch("stallDuringAccess", a);
                stallBurst();
            join
        end
        // nothing pending now
        repeat (8) begin
            @(negedge clk);
            if (fetchAck || dataAck) begin
                otherErrors++;
                $display("stallDuringAccess: an ack was high with no request pending");
            end
        end
    endtask

    task automatic randomSequence();
        logic [31:0] r;
        addrType     a;
        logic [4:0]  off;
        int          nBytes;
        for (int i = 0; i < 8; i++) begin
            storeData(windowBase + addrType'(i * 4), 4, lcgNext());
        end
        for (int i = 0; i < randomCount; i++) begin
            r = lcgNext();
            case (r[3:2])
                2'd0: nBytes = 1;
                2'd1: nBytes = 2;
                default: nBytes = 4;
            endcase
            if (r[1:0] == 2'd1) nBytes = 4;
            // offset inside the window aligned to the size
            off = r[8:4] & ~(5'(nBytes) - 5'd1);
            a = windowBase + addrType'(off);
            if (r[1:0] == 2'd0) begin
                storeData(a, nBytes, lcgNext());
            end else if (r[1:0] == 2'd1) begin
                checkFetch("randomSequence", a);
            end else begin
                checkLoad("randomSequence", a, nBytes);
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the DUT did not finish the tests within %0d cycles", cycleLimit);
            $display("error counts: %0d value mismatches, %0d other failures",
                     valueErrors, otherErrors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        stall = 1'b0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataKind = memPkg::kindLoad;
        dataLen = memPkg::lenOne;
        dataAddr = '0;
        dataWdata = '0;
        repeat (2) @(posedge clk);
        while (rst) @(posedge clk);
        @(negedge clk);
        wordStoreReadBack();
        narrowAccess();
        simultaneousRequests();
        stallDuringAccess();
        randomSequence();
        $display("error counts: %0d value mismatches, %0d other failures",
                 valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- memSubsystem.f
hdl/memPkg.sv
hdl/memArbiter.sv
hdl/byteSequencer.sv
hdl/byteRam.sv
hdl/memSubsystem.sv
verif/clockGen.sv
verif/memSubsystem_props.sv
verif/memSubsystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memSubsystem regression with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module memSubsystemTb \
    -f memSubsystem.f \
    -o memSubsystemSim

./obj_dir/memSubsystemSim | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "Regression passed" sim.log; then
    echo "simulation ended without a result line, see sim.log"
    exit 1
fi
